/* common/dcache_geometry_pkg.sv */
package dcache_geometry_pkg;

    // address split
    localparam int tag_width = 20;
    localparam int index_width = 8;
    localparam int offset_width = 4;

    // line shape
    localparam int line_bytes = 16;
    localparam int line_words = 4;
    localparam int line_width = 128;

    typedef logic [tag_width-1:0] tag_t;
    typedef logic [index_width-1:0] index_t;
    typedef logic [offset_width-1:0] offset_t;

    // word number inside a line
    typedef logic [$clog2(line_words)-1:0] word_sel_t;

    typedef logic [31:0] word_t;
    typedef logic [3:0] wstrb_t;

    typedef logic [line_width-1:0] line_t;
    typedef logic [line_bytes-1:0] line_strb_t;

    typedef logic [tag_width+index_width+offset_width-1:0] mem_addr_t;

endpackage

/* common/dcache_ctrl_pkg.sv */
package dcache_ctrl_pkg;

    // pipe operation codes
    typedef logic [2:0] op_t;

    localparam op_t op_read = 3'b000;
    localparam op_t op_write = 3'b001;

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,
        writeback,
        refill
    } ctrl_state_t;

endpackage

/* source/dcache_request_stage.sv */
module dcache_request_stage (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            accept,
    input  dcache_ctrl_pkg::op_t            op,
    input  dcache_geometry_pkg::tag_t       tag,
    input  dcache_geometry_pkg::index_t     index,
    input  dcache_geometry_pkg::offset_t    offset,
    input  dcache_geometry_pkg::wstrb_t     wstrb,
    input  dcache_geometry_pkg::word_t      wdata,
    output dcache_ctrl_pkg::op_t            req_op,
    output dcache_geometry_pkg::tag_t       req_tag,
    output dcache_geometry_pkg::index_t     req_index,
    output dcache_geometry_pkg::word_sel_t  req_word,
    output dcache_geometry_pkg::line_strb_t req_line_strb,
    output dcache_geometry_pkg::line_t      req_write_line
);

    localparam int word_bits = $bits(dcache_geometry_pkg::word_t);
    localparam int strb_bits = $bits(dcache_geometry_pkg::wstrb_t);

    dcache_geometry_pkg::wstrb_t req_wstrb;
    dcache_geometry_pkg::word_t  req_wdata;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            req_op <= dcache_ctrl_pkg::op_read;
        end else if (accept) begin
            req_op <= op;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_tag <= tag;
            req_index <= index;
            req_word <= offset[dcache_geometry_pkg::offset_width-1:2];
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    // reads carry an empty mask so the merge leaves the line untouched
    always_comb begin
        req_line_strb = '0;
        req_write_line = '0;
        if (req_op == dcache_ctrl_pkg::op_write) begin
            req_line_strb[req_word*strb_bits +: strb_bits] = req_wstrb;
        end
        req_write_line[req_word*word_bits +: word_bits] = req_wdata;
    end

endmodule

/* way_store/dcache_way_store.sv */
module dcache_way_store #(
    parameter int num_ways = 2
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          read_en,
    input  dcache_geometry_pkg::index_t   read_index,
    input  logic                          write_en,
    input  dcache_geometry_pkg::index_t   write_index,
    input  logic [$clog2(num_ways)-1:0]   write_way,
    input  dcache_geometry_pkg::tag_t     write_tag,
    input  dcache_geometry_pkg::line_t    write_line,
    input  logic                          write_dirty,
    output dcache_geometry_pkg::tag_t     way_tag [num_ways],
    output dcache_geometry_pkg::line_t    way_line [num_ways],
    output logic [num_ways-1:0]           way_valid,
    output logic [num_ways-1:0]           way_dirty
);

    localparam int num_sets = 2 ** dcache_geometry_pkg::index_width;

    dcache_geometry_pkg::tag_t  tag_mem [num_ways][num_sets];
    dcache_geometry_pkg::line_t data_mem [num_ways][num_sets];
    logic [num_sets-1:0]        valid_mem [num_ways];
    logic [num_sets-1:0]        dirty_mem [num_ways];

    always_ff @(posedge clk) begin
        if (write_en) begin
            tag_mem[write_way][write_index] <= write_tag;
            data_mem[write_way][write_index] <= write_line;
            dirty_mem[write_way][write_index] <= write_dirty;
        end
    end

    // only the valid bits start from a known state
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_mem <= '{default: '0};
        end else if (write_en) begin
            valid_mem[write_way][write_index] <= 1'b1;
        end
    end

    // whole set of every way, held until the next accepted request
    always_ff @(posedge clk) begin
        if (read_en) begin
            for (int w = 0; w < num_ways; w++) begin
                way_tag[w] <= tag_mem[w][read_index];
                way_line[w] <= data_mem[w][read_index];
                way_valid[w] <= valid_mem[w][read_index];
                way_dirty[w] <= dirty_mem[w][read_index];
            end
        end
    end

endmodule

/* source/dcache_lookup_stage.sv */
module dcache_lookup_stage #(
    parameter int num_ways = 2
) (
    input  dcache_geometry_pkg::tag_t       req_tag,
    input  dcache_geometry_pkg::word_sel_t  req_word,
    input  dcache_geometry_pkg::line_strb_t req_line_strb,
    input  dcache_geometry_pkg::line_t      req_write_line,
    input  dcache_geometry_pkg::tag_t       way_tag [num_ways],
    input  logic [num_ways-1:0]             way_valid,
    input  dcache_geometry_pkg::line_t      way_line [num_ways],
    input  dcache_geometry_pkg::line_t      fill_line,
    input  logic                            use_fill,
    output logic                            hit,
    output logic [$clog2(num_ways)-1:0]     hit_way,
    output dcache_geometry_pkg::word_t      rdata,
    output dcache_geometry_pkg::line_t      merged_line
);

    localparam int way_bits = $clog2(num_ways);
    localparam int word_bits = $bits(dcache_geometry_pkg::word_t);

    logic [num_ways-1:0]        hit_mask;
    dcache_geometry_pkg::line_t base_line;

    // tags are unique within a set, so at most one way matches
    always_comb begin
        hit_mask = '0;
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_mask[w] = way_valid[w] && (way_tag[w] == req_tag);
            if (hit_mask[w]) begin
                hit_way = way_bits'(w);
            end
        end
    end

    assign hit = |hit_mask;

    assign base_line = use_fill ? fill_line : way_line[hit_way];

    assign rdata = base_line[req_word*word_bits +: word_bits];

    // strobed bytes from the request, rest from the base line
    always_comb begin
        for (int b = 0; b < dcache_geometry_pkg::line_bytes; b++) begin
            merged_line[b*8 +: 8] = req_line_strb[b] ? req_write_line[b*8 +: 8]
                                                     : base_line[b*8 +: 8];
        end
    end

endmodule

/* miss_ctrl/dcache_miss_ctrl.sv */
module dcache_miss_ctrl #(
    parameter int num_ways = 2
) (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           valid,
    input  dcache_ctrl_pkg::op_t           req_op,
    input  dcache_geometry_pkg::tag_t      req_tag,
    input  dcache_geometry_pkg::index_t    req_index,
    input  logic                           hit,
    input  logic [$clog2(num_ways)-1:0]    hit_way,
    input  dcache_geometry_pkg::tag_t      way_tag [num_ways],
    input  dcache_geometry_pkg::line_t     way_line [num_ways],
    input  logic [num_ways-1:0]            way_valid,
    input  logic [num_ways-1:0]            way_dirty,
    input  logic                           rd_rdy,
    input  logic                           ret_valid,
    input  logic                           ret_last,
    input  dcache_geometry_pkg::word_t     ret_data,
    input  logic                           wr_rdy,
    output logic                           addr_ok,
    output logic                           data_ok,
    output logic                           use_fill,
    output dcache_geometry_pkg::line_t     fill_line,
    output logic                           store_write_en,
    output logic [$clog2(num_ways)-1:0]    store_write_way,
    output logic                           store_write_dirty,
    output logic                           rd_req,
    output dcache_geometry_pkg::mem_addr_t rd_addr,
    output logic                           wr_req,
    output dcache_geometry_pkg::mem_addr_t wr_addr,
    output dcache_geometry_pkg::line_t     wr_data
);

    localparam int way_bits = $clog2(num_ways);
    localparam int word_bits = $bits(dcache_geometry_pkg::word_t);
    localparam int offset_width = dcache_geometry_pkg::offset_width;

    dcache_ctrl_pkg::ctrl_state_t   state;
    logic [way_bits-1:0]            victim;
    logic                           victim_dirty;
    logic                           rd_sent;
    dcache_geometry_pkg::word_sel_t beat_cnt;
    dcache_geometry_pkg::line_t     fill_buf;

    logic is_write;
    logic in_lookup;
    logic in_refill;
    logic read_hit;
    logic hit_write;
    logic refill_done;

    assign is_write = req_op == dcache_ctrl_pkg::op_write;
    assign in_lookup = state == dcache_ctrl_pkg::lookup;
    assign in_refill = state == dcache_ctrl_pkg::refill;
    assign read_hit = in_lookup && hit && !is_write;
    assign hit_write = in_lookup && hit && is_write;
    assign refill_done = in_refill && ret_valid && ret_last;

    // a read hit frees the lookup slot for the next request
    assign addr_ok = valid && (state == dcache_ctrl_pkg::idle || read_hit);

    // writes are posted, so they finish in lookup even on a miss
    assign data_ok = (in_lookup && (hit || is_write)) || (refill_done && !is_write);

    assign victim_dirty = way_valid[victim] && way_dirty[victim];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= dcache_ctrl_pkg::idle;
        end else begin
            case (state)
                dcache_ctrl_pkg::idle: begin
                    if (addr_ok) begin
                        state <= dcache_ctrl_pkg::lookup;
                    end
                end
                dcache_ctrl_pkg::lookup: begin
                    if (!hit) begin
                        state <= dcache_ctrl_pkg::miss;
                    end else if (!addr_ok) begin
                        state <= dcache_ctrl_pkg::idle;
                    end
                end
                dcache_ctrl_pkg::miss: begin
                    state <= victim_dirty ? dcache_ctrl_pkg::writeback : dcache_ctrl_pkg::refill;
                end
                dcache_ctrl_pkg::writeback: begin
                    if (wr_rdy) begin
                        state <= dcache_ctrl_pkg::refill;
                    end
                end
                dcache_ctrl_pkg::refill: begin
                    if (refill_done) begin
                        state <= dcache_ctrl_pkg::idle;
                    end
                end
                default: begin
                    state <= dcache_ctrl_pkg::idle;
                end
            endcase
        end
    end

    // round robin replacement
    always_ff @(posedge clk) begin
        if (!resetn) begin
            victim <= '0;
        end else if (refill_done) begin
            victim <= (victim == way_bits'(num_ways - 1)) ? '0 : victim + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || !in_refill) begin
            rd_sent <= 1'b0;
        end else if (rd_rdy) begin
            rd_sent <= 1'b1;
        end
    end

    // beats come lowest word first, counter wraps after the last one
    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_cnt <= '0;
        end else if (in_refill && ret_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_refill && ret_valid) begin
            fill_buf <= fill_line;
        end
    end

    always_comb begin
        fill_line = fill_buf;
        if (ret_valid) begin
            fill_line[beat_cnt*word_bits +: word_bits] = ret_data;
        end
    end

    assign use_fill = in_refill;

    assign store_write_en = hit_write || refill_done;
    assign store_write_way = in_lookup ? hit_way : victim;
    assign store_write_dirty = is_write;

    assign rd_req = in_refill && !rd_sent;
    assign rd_addr = {req_tag, req_index, {offset_width{1'b0}}};

    assign wr_req = state == dcache_ctrl_pkg::writeback;
    assign wr_addr = {way_tag[victim], req_index, {offset_width{1'b0}}};
    assign wr_data = way_line[victim];

endmodule

/* source/dcache_top.sv */
module dcache_top #(
    parameter int num_ways = 2
) (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           valid,
    input  dcache_ctrl_pkg::op_t           op,
    input  dcache_geometry_pkg::tag_t      tag,
    input  dcache_geometry_pkg::index_t    index,
    input  dcache_geometry_pkg::offset_t   offset,
    input  dcache_geometry_pkg::wstrb_t    wstrb,
    input  dcache_geometry_pkg::word_t     wdata,
    output logic                           addr_ok,
    output logic                           data_ok,
    output dcache_geometry_pkg::word_t     rdata,
    output logic                           rd_req,
    output dcache_geometry_pkg::mem_addr_t rd_addr,
    input  logic                           rd_rdy,
    input  logic                           ret_valid,
    input  logic                           ret_last,
    input  dcache_geometry_pkg::word_t     ret_data,
    output logic                           wr_req,
    output dcache_geometry_pkg::mem_addr_t wr_addr,
    output dcache_geometry_pkg::line_t     wr_data,
    input  logic                           wr_rdy
);

    dcache_ctrl_pkg::op_t             req_op;
    dcache_geometry_pkg::tag_t        req_tag;
    dcache_geometry_pkg::index_t      req_index;
    dcache_geometry_pkg::word_sel_t   req_word;
    dcache_geometry_pkg::line_strb_t  req_line_strb;
    dcache_geometry_pkg::line_t       req_write_line;

    dcache_geometry_pkg::tag_t        way_tag [num_ways];
    dcache_geometry_pkg::line_t       way_line [num_ways];
    logic [num_ways-1:0]              way_valid;
    logic [num_ways-1:0]              way_dirty;

    logic                             hit;
    logic [$clog2(num_ways)-1:0]      hit_way;
    logic                             use_fill;
    dcache_geometry_pkg::line_t       fill_line;
    dcache_geometry_pkg::line_t       merged_line;

    logic                             store_write_en;
    logic [$clog2(num_ways)-1:0]      store_write_way;
    logic                             store_write_dirty;

    dcache_request_stage i_request_stage (
        .clk            (clk),
        .resetn         (resetn),
        .accept         (addr_ok),
        .op             (op),
        .tag            (tag),
        .index          (index),
        .offset         (offset),
        .wstrb          (wstrb),
        .wdata          (wdata),
        .req_op         (req_op),
        .req_tag        (req_tag),
        .req_index      (req_index),
        .req_word       (req_word),
        .req_line_strb  (req_line_strb),
        .req_write_line (req_write_line)
    );

    // set read launched together with request acceptance
    dcache_way_store #(
        .num_ways (num_ways)
    ) i_way_store (
        .clk         (clk),
        .resetn      (resetn),
        .read_en     (addr_ok),
        .read_index  (index),
        .write_en    (store_write_en),
        .write_index (req_index),
        .write_way   (store_write_way),
        .write_tag   (req_tag),
        .write_line  (merged_line),
        .write_dirty (store_write_dirty),
        .way_tag     (way_tag),
        .way_line    (way_line),
        .way_valid   (way_valid),
        .way_dirty   (way_dirty)
    );

    dcache_lookup_stage #(
        .num_ways (num_ways)
    ) i_lookup_stage (
        .req_tag        (req_tag),
        .req_word       (req_word),
        .req_line_strb  (req_line_strb),
        .req_write_line (req_write_line),
        .way_tag        (way_tag),
        .way_valid      (way_valid),
        .way_line       (way_line),
        .fill_line      (fill_line),
        .use_fill       (use_fill),
        .hit            (hit),
        .hit_way        (hit_way),
        .rdata          (rdata),
        .merged_line    (merged_line)
    );

    dcache_miss_ctrl #(
        .num_ways (num_ways)
    ) i_miss_ctrl (
        .clk               (clk),
        .resetn            (resetn),
        .valid             (valid),
        .req_op            (req_op),
        .req_tag           (req_tag),
        .req_index         (req_index),
        .hit               (hit),
        .hit_way           (hit_way),
        .way_tag           (way_tag),
        .way_line          (way_line),
        .way_valid         (way_valid),
        .way_dirty         (way_dirty),
        .rd_rdy            (rd_rdy),
        .ret_valid         (ret_valid),
        .ret_last          (ret_last),
        .ret_data          (ret_data),
        .wr_rdy            (wr_rdy),
        .addr_ok           (addr_ok),
        .data_ok           (data_ok),
        .use_fill          (use_fill),
        .fill_line         (fill_line),
        .store_write_en    (store_write_en),
        .store_write_way   (store_write_way),
        .store_write_dirty (store_write_dirty),
        .rd_req            (rd_req),
        .rd_addr           (rd_addr),
        .wr_req            (wr_req),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data)
    );

endmodule

/* verification/dcache_mem_model.sv */
module dcache_mem_model #(
    parameter logic [15:0] seed = 16'd3268
) (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           rd_req,
    input  dcache_geometry_pkg::mem_addr_t rd_addr,
    output logic                           rd_rdy,
    output logic                           ret_valid,
    output logic                           ret_last,
    output dcache_geometry_pkg::word_t     ret_data,
    input  logic                           wr_req,
    input  dcache_geometry_pkg::mem_addr_t wr_addr,
    input  dcache_geometry_pkg::line_t     wr_data,
    output logic                           wr_rdy
);

    dcache_geometry_pkg::word_t mem [4096];
    logic [15:0]                lfsr;
    logic [15:0]                step_a;
    logic [15:0]                step_b;
    logic [11:0]                beat_addr;
    logic [2:0]                 beats_left;

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    // two bits per cycle, one for each ready
    assign step_a = lfsr_next(lfsr);
    assign step_b = lfsr_next(step_a);

    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = 32'h9e3779b9 * (i + 1);
        end
        lfsr = seed;
        rd_rdy = 1'b0;
        wr_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        beats_left = '0;
        beat_addr = '0;
    end

    always @(posedge clk) begin
        if (!resetn) begin
            lfsr <= seed;
            rd_rdy <= 1'b0;
            wr_rdy <= 1'b0;
            ret_valid <= 1'b0;
            ret_last <= 1'b0;
            beats_left <= '0;
        end else begin
            lfsr <= step_b;
            rd_rdy <= !step_a[0] && beats_left == 3'd0 && !(rd_req && rd_rdy);
            wr_rdy <= !step_b[0];
            if (beats_left != 3'd0) begin
                ret_valid <= 1'b1;
                ret_last <= beats_left == 3'd1;
                ret_data <= mem[beat_addr];
                beat_addr <= beat_addr + 1'b1;
                beats_left <= beats_left - 1'b1;
            end else begin
                ret_valid <= 1'b0;
                ret_last <= 1'b0;
                // lowest word of the line goes out first
                if (rd_req && rd_rdy) begin
                    beat_addr <= {rd_addr[13:4], 2'b00};
                    beats_left <= 3'd4;
                end
            end
            if (wr_req && wr_rdy) begin
                for (int k = 0; k < 4; k++) begin
                    mem[{wr_addr[13:4], 2'(k)}] <= wr_data[k*32 +: 32];
                end
            end
        end
    end

endmodule

/* verification/dcache_tb.sv */
module dcache_tb;

    localparam int num_requests = 400;
    localparam int cycle_limit = num_requests * 40;

    logic                           clk;
    logic                           resetn;
    logic                           valid;
    dcache_ctrl_pkg::op_t           op;
    dcache_geometry_pkg::tag_t      tag;
    dcache_geometry_pkg::index_t    index;
    dcache_geometry_pkg::offset_t   offset;
    dcache_geometry_pkg::wstrb_t    wstrb;
    dcache_geometry_pkg::word_t     wdata;
    logic                           addr_ok;
    logic                           data_ok;
    dcache_geometry_pkg::word_t     rdata;
    logic                           rd_req;
    dcache_geometry_pkg::mem_addr_t rd_addr;
    logic                           rd_rdy;
    logic                           ret_valid;
    logic                           ret_last;
    dcache_geometry_pkg::word_t     ret_data;
    logic                           wr_req;
    dcache_geometry_pkg::mem_addr_t wr_addr;
    dcache_geometry_pkg::line_t     wr_data;
    logic                           wr_rdy;

    logic [7:0]                 golden [16384];
    logic [15:0]                lfsr_state;
    // read flag, byte address, expected word
    logic [46:0]                pending [$];
    logic                       read_check;
    logic                       stray_data_ok;
    logic                       repeat_line;
    logic                       prev_seen;
    logic [27:0]                prev_line;
    logic [13:0]                expected_addr;
    dcache_geometry_pkg::word_t expected_word;
    dcache_geometry_pkg::line_t expected_line;
    int                         errors;
    int                         cycles;
    int                         reads_checked;
    int                         writebacks_checked;

    dcache_top i_dcache_top (.*);

    dcache_mem_model #(
        .seed (16'd3268)
    ) i_mem_model (
        .clk       (clk),
        .resetn    (resetn),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] fill_word(input int word_index);
        return 32'h9e3779b9 * (word_index + 1);
    endfunction

    // 3 tags and 2 sets, so each set sees evictions
    task automatic send_request();
        logic [1:0] tag_pick;
        logic [1:0] word_pick;
        tag_pick = 2'(random_bits(2));
        if (tag_pick == 2'd3) begin
            tag_pick = 2'd0;
        end
        word_pick = 2'(random_bits(2));
        @(posedge clk);
        if (random_bits(3) == 0) begin
            valid <= 1'b0;
            @(posedge clk);
        end
        valid <= 1'b1;
        op <= random_bits(1) ? dcache_ctrl_pkg::op_write : dcache_ctrl_pkg::op_read;
        tag <= 20'h1c0a0 + 20'(tag_pick);
        index <= random_bits(1) ? 8'h3a : 8'hc5;
        offset <= {word_pick, 2'b00};
        wstrb <= 4'(random_bits(4));
        wdata <= random_bits(32);
        do begin
            @(negedge clk);
        end while (!addr_ok);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d requests still open", cycles, pending.size());
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // scoreboard, sampled mid-cycle
    always @(negedge clk) begin
        logic [13:0] base;
        logic [46:0] entry;
        read_check = 1'b0;
        stray_data_ok = 1'b0;
        repeat_line = 1'b0;
        if (resetn && data_ok) begin
            if (pending.size() == 0) begin
                stray_data_ok = 1'b1;
            end else begin
                entry = pending.pop_front();
                read_check = entry[46];
                expected_addr = entry[45:32];
                expected_word = entry[31:0];
            end
        end
        if (resetn && valid && addr_ok) begin
            base = {tag[1:0], index, offset[3:2], 2'b00};
            repeat_line = prev_seen && ({tag, index} == prev_line)
                          && op == dcache_ctrl_pkg::op_read;
            prev_line = {tag, index};
            prev_seen = 1'b1;
            if (op == dcache_ctrl_pkg::op_write) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) begin
                        golden[base + b] = wdata[b*8 +: 8];
                    end
                end
                pending.push_back({1'b0, base, 32'h0});
            end else begin
                pending.push_back({1'b1, base, golden[base + 3], golden[base + 2],
                                   golden[base + 1], golden[base]});
            end
        end
        if (resetn && wr_req) begin
            base = {wr_addr[13:4], 4'h0};
            for (int b = 0; b < 16; b++) begin
                expected_line[b*8 +: 8] = golden[base + b];
            end
            if (wr_rdy) begin
                writebacks_checked++;
            end
        end
        if (read_check) begin
            reads_checked++;
        end
    end

    reset_quiet: assert property (@(posedge clk)
        !resetn |=> !addr_ok && !data_ok && !rd_req && !wr_req)
        else begin
            errors++;
            $display("handshake outputs not low right after reset, cycle %0d", cycles);
        end

    read_data: assert property (@(posedge clk) disable iff (!resetn)
        read_check |-> rdata == expected_word)
        else begin
            errors++;
            $display("FAILED rdata at %h: got %h, expected %h",
                     expected_addr, $sampled(rdata), expected_word);
        end

    no_stray: assert property (@(posedge clk) disable iff (!resetn) !stray_data_ok)
        else begin
            errors++;
            $display("data_ok raised with no request outstanding, cycle %0d", cycles);
        end

    write_latency: assert property (@(posedge clk) disable iff (!resetn)
        valid && addr_ok && op == dcache_ctrl_pkg::op_write |=> data_ok)
        else begin
            errors++;
            $display("write data_ok missing one cycle after acceptance, cycle %0d", cycles);
        end

    // same line as the previous request must already be resident
    repeat_hit: assert property (@(posedge clk) disable iff (!resetn) repeat_line |=> data_ok)
        else begin
            errors++;
            $display("repeated line did not hit one cycle after acceptance, cycle %0d", cycles);
        end

    wb_align: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && wr_rdy |-> wr_addr[3:0] == 4'h0)
        else begin
            errors++;
            $display("FAILED wr_addr: %h is not line aligned", $sampled(wr_addr));
        end

    wb_data: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && wr_rdy |-> wr_data == expected_line)
        else begin
            errors++;
            $display("FAILED wr_data at %h: got %h, expected %h",
                     $sampled(wr_addr), $sampled(wr_data), expected_line);
        end

    rd_align: assert property (@(posedge clk) disable iff (!resetn)
        rd_req |-> rd_addr[3:0] == 4'h0)
        else begin
            errors++;
            $display("FAILED rd_addr: %h is not line aligned", $sampled(rd_addr));
        end

    one_mem_req: assert property (@(posedge clk) disable iff (!resetn) !(rd_req && wr_req))
        else begin
            errors++;
            $display("rd_req and wr_req both high, cycle %0d", cycles);
        end

    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        valid = 1'b0;
        op = dcache_ctrl_pkg::op_read;
        tag = '0;
        index = '0;
        offset = '0;
        wstrb = '0;
        wdata = '0;
        lfsr_state = 16'd3268;
        prev_seen = 1'b0;
        prev_line = '0;
        read_check = 1'b0;
        stray_data_ok = 1'b0;
        repeat_line = 1'b0;
        errors = 0;
        cycles = 0;
        reads_checked = 0;
        writebacks_checked = 0;
        for (int w = 0; w < 4096; w++) begin
            for (int b = 0; b < 4; b++) begin
                golden[w*4 + b] = 8'(fill_word(w) >> (b*8));
            end
        end
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        for (int n = 0; n < num_requests; n++) begin
            send_request();
        end
        @(posedge clk);
        valid <= 1'b0;
        while (pending.size() != 0) begin
            @(negedge clk);
        end
        // let the last check run
        @(posedge clk);
        @(negedge clk);
        $display("requests %0d, reads checked %0d, writebacks checked %0d, errors %0d",
                 num_requests, reads_checked, writebacks_checked, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* dcache.f */
common/dcache_geometry_pkg.sv
common/dcache_ctrl_pkg.sv
source/dcache_request_stage.sv
way_store/dcache_way_store.sv
source/dcache_lookup_stage.sv
miss_ctrl/dcache_miss_ctrl.sv
source/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - files:
      - common/dcache_geometry_pkg.sv
      - common/dcache_ctrl_pkg.sv
      - source/dcache_request_stage.sv
      - way_store/dcache_way_store.sv
      - source/dcache_lookup_stage.sv
      - miss_ctrl/dcache_miss_ctrl.sv
      - source/dcache_top.sv
  - target: test
    files:
      - verification/dcache_mem_model.sv
      - verification/dcache_tb.sv
